//--- logic/igr_pkg.sv
// shared sizes and types for the ingress dpc slice
// four logical ports share one epl receive bus, up to eight words a segment
// only tc, sop, eop, eop_pos and error are kept from the epl metadata
// the ecc byte of the bus is not carried

package igr_pkg;

  // --------------------
  // sizes
  // --------------------

  // logical ports multiplexed on the receive bus
  localparam int num_ports = 4;
  // 64-bit words per bus segment
  localparam int num_words = 8;
  // pfc traffic classes
  localparam int num_tc = 8;

  localparam int port_w = $clog2(num_ports);
  localparam int tc_w = $clog2(num_tc);
  // wide enough to hold num_words itself
  localparam int word_cnt_w = $clog2(num_words + 1);
  localparam int drop_cnt_w = 16;
  localparam int ts_w = 32;
  localparam int data_w = 64;

  // --------------------
  // scalar types
  // --------------------

  typedef logic [port_w-1:0] port_num_t;
  typedef logic [tc_w-1:0] tc_t;
  typedef logic [word_cnt_w-1:0] word_cnt_t;
  // free running, wraps at 2**16
  typedef logic [drop_cnt_w-1:0] drop_cnt_t;
  typedef logic [ts_w-1:0] ts_t;
  typedef logic [data_w-1:0] data_word_t;

  // word 0 sits in the low slice
  typedef data_word_t [num_words-1:0] seg_data_t;

  // --------------------
  // metadata and segments
  // --------------------

  // metadata as it comes off the epl bus
  typedef struct packed {
    tc_t        tc;
    logic       sop;
    logic       eop;
    logic [2:0] eop_pos;
    logic       error;
  } epl_md_t;

  // epl metadata plus the count of valid words in the segment
  typedef struct packed {
    word_cnt_t  word_cnt;
    tc_t        tc;
    logic       sop;
    logic       eop;
    logic [2:0] eop_pos;
    logic       error;
  } dpc_md_t;

  // one per-port segment, v is a single cycle strobe
  typedef struct packed {
    logic      v;
    ts_t       ts;
    dpc_md_t   md;
    seg_data_t d;
  } seg_t;

  // pause bit per port and traffic class, indexed [port][tc]
  typedef logic [num_ports-1:0][num_tc-1:0] pause_vec_t;

endpackage

//--- logic/igr_dpc.sv
// splits the shared epl receive bus into one segment stream per port
// two register stages, a segment shows on its port two clocks after capture
// a segment exists only when some word-valid bit is set
// ts, md and d of a port hold their last value while its v is low
// no back-pressure, downstream takes every strobe

`timescale 1ns/1ns

module igr_dpc (
  input  logic                                   cclk,
  input  logic                                   rst,
  input  igr_pkg::port_num_t                     i_rx_port_num,
  input  logic [igr_pkg::num_words-1:0]          i_rx_data_v,
  input  igr_pkg::seg_data_t                     i_rx_data,
  input  igr_pkg::epl_md_t                       i_rx_md,
  input  igr_pkg::ts_t                           i_rx_ts,
  output igr_pkg::seg_t [igr_pkg::num_ports-1:0] o_seg
);
  import igr_pkg::*;

  // stage 1 copies of the bus
  port_num_t            qs1_port_num;
  logic [num_words-1:0] qs1_data_v;
  seg_data_t            qs1_data;
  epl_md_t              qs1_md;
  ts_t                  qs1_ts;

  // stage 1 decode
  logic [num_ports-1:0] s1_port_hot;
  logic                 s1_any_v;
  word_cnt_t            s1_word_cnt;
  dpc_md_t              s1_md;

  // stage 2 per-port segments
  seg_t [num_ports-1:0] qs2_seg;
  logic [num_ports-1:0] s2_port_v;

  // population count of the word-valid mask, 0 to num_words
  function automatic word_cnt_t count_ones(input logic [num_words-1:0] mask);
    word_cnt_t cnt;
    cnt = '0;
    for (int i = 0; i < num_words; i++) begin
      cnt = cnt + word_cnt_t'(mask[i]);
    end
    return cnt;
  endfunction

  // --------------------
  // stage 1
  // --------------------

  // mask cleared so no phantom segment leaves reset
  always_ff @(posedge cclk) begin
    if (rst) begin
      qs1_data_v <= '0;
    end else begin
      qs1_data_v <= i_rx_data_v;
    end
  end

  // payload side of the bus, only looked at when the mask is set
  always_ff @(posedge cclk) begin
    qs1_port_num <= i_rx_port_num;
    qs1_data     <= i_rx_data;
    qs1_md       <= i_rx_md;
    qs1_ts       <= i_rx_ts;
  end

  // one-hot port decode
  always_comb begin
    for (int p = 0; p < num_ports; p++) begin
      s1_port_hot[p] = (qs1_port_num == port_num_t'(p));
    end
  end

  assign s1_any_v    = |qs1_data_v;
  assign s1_word_cnt = count_ones(qs1_data_v);

  // dpc metadata, epl fields plus the word count
  always_comb begin
    s1_md.word_cnt = s1_word_cnt;
    s1_md.tc       = qs1_md.tc;
    s1_md.sop      = qs1_md.sop;
    s1_md.eop      = qs1_md.eop;
    s1_md.eop_pos  = qs1_md.eop_pos;
    s1_md.error    = qs1_md.error;
  end

  // --------------------
  // stage 2
  // --------------------

  // capture only on the addressed port, others keep their old fields
  always_ff @(posedge cclk) begin
    if (rst) begin
      qs2_seg <= '0;
    end else begin
      for (int p = 0; p < num_ports; p++) begin
        qs2_seg[p].v <= s1_any_v && s1_port_hot[p];
        if (s1_any_v && s1_port_hot[p]) begin
          qs2_seg[p].ts <= qs1_ts;
          qs2_seg[p].md <= s1_md;
          qs2_seg[p].d  <= qs1_data;
        end
      end
    end
  end

  assign o_seg = qs2_seg;

  // gather the strobes for the check below
  always_comb begin
    for (int p = 0; p < num_ports; p++) begin
      s2_port_v[p] = qs2_seg[p].v;
    end
  end

  // one bus segment feeds at most one port per cycle
  a_port_v_onehot0 : assert property (
    @(posedge cclk) disable iff (rst)
    $onehot0(s2_port_v)
  );

endmodule

//--- logic/igr_pause_ctrl.sv
// pfc pause state per logical port and traffic class
// xoff is a level, sampled every cycle with or without a segment
// two register stages, lined up with the dpc demux so a same-cycle
// xoff reaches the drop decision of its own segment

`timescale 1ns/1ns

module igr_pause_ctrl (
  input  logic                cclk,
  input  logic                rst,
  input  igr_pkg::port_num_t  i_rx_port_num,
  input  logic                i_rx_pfc_xoff,
  input  igr_pkg::tc_t        i_rx_fc_tc,
  output igr_pkg::pause_vec_t o_pause
);
  import igr_pkg::*;

  // stage 1 copies
  port_num_t  qs1_port_num;
  logic       qs1_xoff;
  tc_t        qs1_fc_tc;

  // pause bits, [port][tc]
  pause_vec_t q_pause;

  // --------------------
  // stage 1
  // --------------------

  // xoff cleared in reset so the first write after reset is a zero
  always_ff @(posedge cclk) begin
    if (rst) begin
      qs1_port_num <= '0;
      qs1_xoff     <= 1'b0;
      qs1_fc_tc    <= '0;
    end else begin
      qs1_port_num <= i_rx_port_num;
      qs1_xoff     <= i_rx_pfc_xoff;
      qs1_fc_tc    <= i_rx_fc_tc;
    end
  end

  // --------------------
  // state update
  // --------------------

  // exactly one bit written per cycle, the rest hold
  always_ff @(posedge cclk) begin
    if (rst) begin
      q_pause <= '0;
    end else begin
      q_pause[qs1_port_num][qs1_fc_tc] <= qs1_xoff;
    end
  end

  assign o_pause = q_pause;

  // no stale pause survives a reset
  a_pause_clear_after_rst : assert property (
    @(posedge cclk)
    rst |=> (o_pause == '0)
  );

endmodule

//--- logic/igr_drop_ctrl.sv
// whole-packet drop filter for one logical port
// the class of the sop segment decides for the whole packet, through eop
// one register stage, output fields hold the last forwarded segment
// drop count wraps, one count per dropped packet

`timescale 1ns/1ns

module igr_drop_ctrl (
  input  logic                       cclk,
  input  logic                       rst,
  input  igr_pkg::seg_t              i_seg,
  input  logic [igr_pkg::num_tc-1:0] i_pause,
  output igr_pkg::seg_t              o_seg,
  output igr_pkg::drop_cnt_t         o_drop_cnt
);
  import igr_pkg::*;

  tc_t  s_tc;
  logic s_start;
  logic s_end;
  logic s_tc_paused;
  logic s_drop_start;
  logic s_drop;
  logic s_fwd;

  // set between a dropped sop and its eop
  logic q_in_drop;

  // --------------------
  // decision
  // --------------------

  assign s_tc         = i_seg.md.tc;
  assign s_start      = i_seg.v && i_seg.md.sop;
  assign s_end        = i_seg.v && i_seg.md.eop;
  assign s_tc_paused  = i_pause[s_tc];
  assign s_drop_start = s_start && s_tc_paused;

  // sop decides afresh, later segments follow the flag
  assign s_drop = s_start ? s_tc_paused : (i_seg.v && q_in_drop);
  assign s_fwd  = i_seg.v && !s_drop;

  // a one-segment packet never leaves the flag set
  always_ff @(posedge cclk) begin
    if (rst) begin
      q_in_drop <= 1'b0;
    end else if (s_start) begin
      q_in_drop <= s_tc_paused && !i_seg.md.eop;
    end else if (s_end) begin
      q_in_drop <= 1'b0;
    end
  end

  // --------------------
  // output register
  // --------------------

  always_ff @(posedge cclk) begin
    if (rst) begin
      o_seg <= '0;
    end else begin
      o_seg.v <= s_fwd;
      if (s_fwd) begin
        o_seg.ts <= i_seg.ts;
        o_seg.md <= i_seg.md;
        o_seg.d  <= i_seg.d;
      end
    end
  end

  // counted on the sop only
  always_ff @(posedge cclk) begin
    if (rst) begin
      o_drop_cnt <= '0;
    end else if (s_drop_start) begin
      o_drop_cnt <= o_drop_cnt + drop_cnt_t'(1);
    end
  end

  // a segment classed as dropped never shows a strobe downstream
  a_no_strobe_on_drop : assert property (
    @(posedge cclk) disable iff (rst)
    s_drop |=> !o_seg.v
  );

endmodule

//--- logic/igr_top.sv
// ingress dpc slice, demux plus pfc pause tracking plus per-port drop
// fixed three clock latency from bus capture to per-port strobe
// no back-pressure, every output strobe must be taken

`timescale 1ns/1ns

module igr_top (
  input  logic                                        cclk,
  input  logic                                        rst,
  input  igr_pkg::port_num_t                          i_rx_port_num,
  input  logic [igr_pkg::num_words-1:0]               i_rx_data_v,
  input  igr_pkg::seg_data_t                          i_rx_data,
  input  igr_pkg::epl_md_t                            i_rx_md,
  input  igr_pkg::ts_t                                i_rx_ts,
  input  logic                                        i_rx_pfc_xoff,
  input  igr_pkg::tc_t                                i_rx_fc_tc,
  output igr_pkg::seg_t [igr_pkg::num_ports-1:0]      o_seg,
  output igr_pkg::drop_cnt_t [igr_pkg::num_ports-1:0] o_drop_cnt
);
  import igr_pkg::*;

  // demux output, one stream per port
  seg_t [num_ports-1:0] dpc_seg;
  // pause rows, one per port
  pause_vec_t           pause;

  // --------------------
  // bus demux
  // --------------------

  igr_dpc igr_dpc_inst (
    .cclk          (cclk),
    .rst           (rst),
    .i_rx_port_num (i_rx_port_num),
    .i_rx_data_v   (i_rx_data_v),
    .i_rx_data     (i_rx_data),
    .i_rx_md       (i_rx_md),
    .i_rx_ts       (i_rx_ts),
    .o_seg         (dpc_seg)
  );

  // pause state sees the same port number as the demux
  igr_pause_ctrl igr_pause_ctrl_inst (
    .cclk          (cclk),
    .rst           (rst),
    .i_rx_port_num (i_rx_port_num),
    .i_rx_pfc_xoff (i_rx_pfc_xoff),
    .i_rx_fc_tc    (i_rx_fc_tc),
    .o_pause       (pause)
  );

  // --------------------
  // per-port drop
  // --------------------

  for (genvar p = 0; p < num_ports; p++) begin : g_port
    igr_drop_ctrl igr_drop_ctrl_inst (
      .cclk       (cclk),
      .rst        (rst),
      .i_seg      (dpc_seg[p]),
      .i_pause    (pause[p]),
      .o_seg      (o_seg[p]),
      .o_drop_cnt (o_drop_cnt[p])
    );
  end

endmodule

//--- tests/igr_tb_table.svh
// stimulus table for the ingress dpc testbench, one row per clock
// expected outputs come from the reference model in the testbench
// fwd is the hand-written forward or drop expectation for the row's segment
// a row with no mask bit set carries no segment, but its xoff still counts

`ifndef igr_tb_table_svh
`define igr_tb_table_svh

// test  rst  port  mask  sop  eop  err  tc  xoff  fc_tc  seed  ts  fwd
typedef struct packed {
  logic [3:0]  test;
  logic        rst;
  port_num_t   port;
  logic [7:0]  mask;
  logic        sop;
  logic        eop;
  logic        err;
  tc_t         tc;
  logic        xoff;
  tc_t         fc_tc;
  logic [15:0] seed;
  ts_t         ts;
  logic        fwd;
} row_t;

localparam int num_rows = 34;

localparam row_t rows [num_rows] = '{
  // one-segment packets to each port
  '{4'd1, 1'b0, 2'd0, 8'hff, 1'b1, 1'b1, 1'b0, 3'd0, 1'b0, 3'd0, 16'h1100, 32'h100, 1'b1},
  '{4'd1, 1'b0, 2'd1, 8'hff, 1'b1, 1'b1, 1'b0, 3'd1, 1'b0, 3'd0, 16'h1101, 32'h101, 1'b1},
  '{4'd1, 1'b0, 2'd2, 8'hff, 1'b1, 1'b1, 1'b0, 3'd2, 1'b0, 3'd0, 16'h1102, 32'h102, 1'b1},
  '{4'd1, 1'b0, 2'd3, 8'hff, 1'b1, 1'b1, 1'b0, 3'd3, 1'b0, 3'd0, 16'h1103, 32'h103, 1'b1},
  // word count 0 to 8, empty masks leave port 2 fields alone
  '{4'd2, 1'b0, 2'd2, 8'h00, 1'b0, 1'b0, 1'b0, 3'd0, 1'b0, 3'd0, 16'h2200, 32'h200, 1'b0},
  '{4'd2, 1'b0, 2'd2, 8'h01, 1'b1, 1'b1, 1'b0, 3'd0, 1'b0, 3'd0, 16'h2201, 32'h201, 1'b1},
  '{4'd2, 1'b0, 2'd2, 8'h81, 1'b1, 1'b1, 1'b1, 3'd0, 1'b0, 3'd0, 16'h2202, 32'h202, 1'b1},
  '{4'd2, 1'b0, 2'd2, 8'h07, 1'b1, 1'b1, 1'b0, 3'd0, 1'b0, 3'd0, 16'h2203, 32'h203, 1'b1},
  '{4'd2, 1'b0, 2'd2, 8'h55, 1'b1, 1'b1, 1'b0, 3'd0, 1'b0, 3'd0, 16'h2204, 32'h204, 1'b1},
  '{4'd2, 1'b0, 2'd2, 8'h1f, 1'b1, 1'b1, 1'b0, 3'd0, 1'b0, 3'd0, 16'h2205, 32'h205, 1'b1},
  '{4'd2, 1'b0, 2'd2, 8'h3f, 1'b1, 1'b1, 1'b0, 3'd0, 1'b0, 3'd0, 16'h2206, 32'h206, 1'b1},
  '{4'd2, 1'b0, 2'd2, 8'h7f, 1'b1, 1'b1, 1'b0, 3'd0, 1'b0, 3'd0, 16'h2207, 32'h207, 1'b1},
  '{4'd2, 1'b0, 2'd2, 8'hff, 1'b1, 1'b1, 1'b0, 3'd0, 1'b0, 3'd0, 16'h2208, 32'h208, 1'b1},
  '{4'd2, 1'b0, 2'd2, 8'h00, 1'b0, 1'b0, 1'b0, 3'd0, 1'b0, 3'd0, 16'h2209, 32'h209, 1'b0},
  // xoff on port 1 class 5, then a three-segment packet there
  '{4'd3, 1'b0, 2'd1, 8'h00, 1'b0, 1'b0, 1'b0, 3'd0, 1'b1, 3'd5, 16'h3300, 32'h300, 1'b0},
  '{4'd3, 1'b0, 2'd1, 8'hff, 1'b1, 1'b0, 1'b0, 3'd5, 1'b1, 3'd5, 16'h3301, 32'h301, 1'b0},
  '{4'd3, 1'b0, 2'd1, 8'hff, 1'b0, 1'b0, 1'b0, 3'd5, 1'b1, 3'd5, 16'h3302, 32'h302, 1'b0},
  '{4'd3, 1'b0, 2'd1, 8'h0f, 1'b0, 1'b1, 1'b0, 3'd5, 1'b1, 3'd5, 16'h3303, 32'h303, 1'b0},
  '{4'd3, 1'b0, 2'd2, 8'hff, 1'b1, 1'b1, 1'b0, 3'd5, 1'b0, 3'd0, 16'h3304, 32'h304, 1'b1},
  // release, then xoff arriving in the middle of a packet
  '{4'd4, 1'b0, 2'd1, 8'h00, 1'b0, 1'b0, 1'b0, 3'd0, 1'b0, 3'd5, 16'h4400, 32'h400, 1'b0},
  '{4'd4, 1'b0, 2'd1, 8'hff, 1'b1, 1'b1, 1'b0, 3'd5, 1'b0, 3'd5, 16'h4401, 32'h401, 1'b1},
  '{4'd4, 1'b0, 2'd1, 8'hff, 1'b1, 1'b0, 1'b0, 3'd5, 1'b0, 3'd5, 16'h4402, 32'h402, 1'b1},
  '{4'd4, 1'b0, 2'd1, 8'hff, 1'b0, 1'b0, 1'b0, 3'd5, 1'b1, 3'd5, 16'h4403, 32'h403, 1'b1},
  '{4'd4, 1'b0, 2'd1, 8'h07, 1'b0, 1'b1, 1'b0, 3'd5, 1'b1, 3'd5, 16'h4404, 32'h404, 1'b1},
  // xoff in the very cycle of the sop
  '{4'd5, 1'b0, 2'd0, 8'hff, 1'b1, 1'b0, 1'b0, 3'd6, 1'b1, 3'd6, 16'h5500, 32'h500, 1'b0},
  '{4'd5, 1'b0, 2'd0, 8'h01, 1'b0, 1'b1, 1'b0, 3'd6, 1'b1, 3'd6, 16'h5501, 32'h501, 1'b0},
  '{4'd5, 1'b0, 2'd3, 8'hff, 1'b1, 1'b1, 1'b1, 3'd2, 1'b1, 3'd2, 16'h5502, 32'h502, 1'b0},
  // reset with pause and counters set, then traffic on the paused classes
  '{4'd6, 1'b0, 2'd0, 8'h00, 1'b0, 1'b0, 1'b0, 3'd0, 1'b1, 3'd6, 16'h6600, 32'h600, 1'b0},
  '{4'd6, 1'b0, 2'd0, 8'h00, 1'b0, 1'b0, 1'b0, 3'd0, 1'b1, 3'd6, 16'h6601, 32'h601, 1'b0},
  '{4'd6, 1'b1, 2'd0, 8'h00, 1'b0, 1'b0, 1'b0, 3'd0, 1'b0, 3'd0, 16'h6602, 32'h602, 1'b0},
  '{4'd6, 1'b1, 2'd0, 8'h00, 1'b0, 1'b0, 1'b0, 3'd0, 1'b0, 3'd0, 16'h6603, 32'h603, 1'b0},
  '{4'd6, 1'b1, 2'd0, 8'h00, 1'b0, 1'b0, 1'b0, 3'd0, 1'b0, 3'd0, 16'h6604, 32'h604, 1'b0},
  '{4'd6, 1'b0, 2'd0, 8'hff, 1'b1, 1'b1, 1'b0, 3'd6, 1'b0, 3'd0, 16'h6605, 32'h605, 1'b1},
  '{4'd6, 1'b0, 2'd3, 8'h0f, 1'b1, 1'b1, 1'b0, 3'd2, 1'b0, 3'd0, 16'h6606, 32'h606, 1'b1}
};

`endif

//--- tests/igr_tb.sv
// testbench for the ingress dpc slice, one table row per clock
// inputs change on the falling edge, outputs are compared three clocks later
// expected values come from a reference model of the pause and drop rules
// data words are random from a fixed seed, so every run is the same

`timescale 1ns/1ns

module igr_tb;
  import igr_pkg::*;

  `include "igr_tb_table.svh"

  localparam int num_tests = 6;

  // expected top outputs for one row, after its three clocks
  typedef struct packed {
    logic [3:0]                test;
    seg_t [num_ports-1:0]      seg;
    drop_cnt_t [num_ports-1:0] cnt;
  } exp_t;

  logic                      cclk;
  logic                      rst;
  port_num_t                 i_rx_port_num;
  logic [num_words-1:0]      i_rx_data_v;
  seg_data_t                 i_rx_data;
  epl_md_t                   i_rx_md;
  ts_t                       i_rx_ts;
  logic                      i_rx_pfc_xoff;
  tc_t                       i_rx_fc_tc;
  seg_t [num_ports-1:0]      o_seg;
  drop_cnt_t [num_ports-1:0] o_drop_cnt;

  // reference model state
  pause_vec_t                m_pause;
  seg_t [num_ports-1:0]      m_out;
  drop_cnt_t [num_ports-1:0] m_cnt;
  logic [num_ports-1:0]      m_in_drop;

  // delay line of expectations, one entry per row in flight
  exp_t exp_q[$];
  int   test_err [1:num_tests];
  int   cur_test = 0;
  int   n_pass = 0;
  int   n_fail = 0;

  igr_top igr_top_inst (
    .cclk          (cclk),
    .rst           (rst),
    .i_rx_port_num (i_rx_port_num),
    .i_rx_data_v   (i_rx_data_v),
    .i_rx_data     (i_rx_data),
    .i_rx_md       (i_rx_md),
    .i_rx_ts       (i_rx_ts),
    .i_rx_pfc_xoff (i_rx_pfc_xoff),
    .i_rx_fc_tc    (i_rx_fc_tc),
    .o_seg         (o_seg),
    .o_drop_cnt    (o_drop_cnt)
  );

  initial begin
    cclk = 1'b0;
    forever #20 cclk = ~cclk;
  end

  // --------------------
  // helpers
  // --------------------

  function automatic string test_name(input int t);
    case (t)
      1: return "demux and latency";
      2: return "valid word count";
      3: return "pause and drop";
      4: return "pause release";
      5: return "same cycle xoff";
      default: return "reset";
    endcase
  endfunction

  task automatic note_error(input int t);
    test_err[t]++;
  endtask

  task automatic report_test(input int t);
    if (test_err[t] == 0) begin
      n_pass++;
      $display("test %0d %s: passed", t, test_name(t));
    end else begin
      n_fail++;
      $display("test %0d %s: failed with %0d errors", t, test_name(t), test_err[t]);
    end
  endtask

  task automatic check_field(input int t, input int p, input string what,
                             input logic [511:0] got, input logic [511:0] want);
    assert (got == want) else begin
      $display("FAIL %0t: test %0d port %0d %s is %0h, expected %0h",
               $time, t, p, what, got, want);
      note_error(t);
    end
  endtask

  task automatic drive_idle();
    rst           = 1'b0;
    i_rx_port_num = '0;
    i_rx_data_v   = '0;
    i_rx_data     = '0;
    i_rx_md       = '0;
    i_rx_ts       = '0;
    i_rx_pfc_xoff = 1'b0;
    i_rx_fc_tc    = '0;
  endtask

  // --------------------
  // reference model
  // --------------------

  // pause is written first, so a same-cycle xoff governs this segment
  task automatic model_step(input row_t row, input seg_data_t data, input epl_md_t md,
                            output exp_t e, output logic fwd);
    port_num_t p;
    logic      drop;
    p = row.port;
    fwd = 1'b0;
    m_pause[p][row.fc_tc] = row.xoff;
    for (int q = 0; q < num_ports; q++) begin
      m_out[q].v = 1'b0;
    end
    if (row.mask != '0) begin
      if (row.sop) begin
        drop = m_pause[p][row.tc];
        m_in_drop[p] = drop && !row.eop;
        if (drop) begin
          m_cnt[p] = m_cnt[p] + 16'd1;
        end
      end else begin
        drop = m_in_drop[p];
        if (row.eop) begin
          m_in_drop[p] = 1'b0;
        end
      end
      if (!drop) begin
        fwd = 1'b1;
        m_out[p].v  = 1'b1;
        m_out[p].ts = row.ts;
        m_out[p].d  = data;
        m_out[p].md = '{word_cnt: word_cnt_t'($countones(row.mask)), tc: md.tc,
                        sop: md.sop, eop: md.eop, eop_pos: md.eop_pos, error: md.error};
      end
    end
    e.test = row.test;
    e.seg  = m_out;
    e.cnt  = m_cnt;
  endtask

  // drives one table row and queues what it should produce
  task automatic apply_row(input int r);
    row_t      row;
    seg_data_t data;
    epl_md_t   md;
    exp_t      e;
    logic      fwd;
    row = rows[r];
    for (int w = 0; w < num_words; w++) begin
      data[w] = {$urandom(), row.seed, 8'(r), 8'(w)};
    end
    md = '{tc: row.tc, sop: row.sop, eop: row.eop, error: row.err,
           eop_pos: row.eop ? 3'($countones(row.mask) - 1) : 3'd0};
    rst           = row.rst;
    i_rx_port_num = row.port;
    i_rx_data_v   = row.mask;
    i_rx_data     = data;
    i_rx_md       = md;
    i_rx_ts       = row.ts;
    i_rx_pfc_xoff = row.xoff;
    i_rx_fc_tc    = row.fc_tc;
    if (row.rst) begin
      // rows still in the pipe come out as reset values
      m_pause = '0;
      m_out = '0;
      m_cnt = '0;
      m_in_drop = '0;
      foreach (exp_q[i]) begin
        exp_q[i].seg = '0;
        exp_q[i].cnt = '0;
      end
      e = '0;
      e.test = row.test;
      fwd = 1'b0;
    end else begin
      model_step(row, data, md, e, fwd);
    end
    assert (fwd == row.fwd) else begin
      $display("test %0d row %0d: reference model and table disagree on forwarding",
               int'(row.test), r);
      note_error(int'(row.test));
    end
    exp_q.push_back(e);
  endtask

  task automatic compare_outputs(input exp_t e);
    int t;
    t = int'(e.test);
    if (t != cur_test) begin
      if (cur_test != 0) begin
        report_test(cur_test);
      end
      cur_test = t;
    end
    for (int p = 0; p < num_ports; p++) begin
      assert (o_seg[p].v == e.seg[p].v) else begin
        if (e.seg[p].v) begin
          $display("test %0d: expected strobe missing on port %0d at %0t", t, p, $time);
        end else begin
          $display("test %0d: unexpected extra strobe on port %0d at %0t", t, p, $time);
        end
        note_error(t);
      end
      check_field(t, p, "ts", 512'(o_seg[p].ts), 512'(e.seg[p].ts));
      check_field(t, p, "md", 512'(o_seg[p].md), 512'(e.seg[p].md));
      check_field(t, p, "data", 512'(o_seg[p].d), 512'(e.seg[p].d));
      check_field(t, p, "drop count", 512'(o_drop_cnt[p]), 512'(e.cnt[p]));
    end
  endtask

  // --------------------
  // main sequence
  // --------------------

  initial begin
    exp_t head;
    void'($urandom(32'hfd9f));
    for (int t = 1; t <= num_tests; t++) begin
      test_err[t] = 0;
    end
    drive_idle();
    rst = 1'b1;
    m_pause = '0;
    m_out = '0;
    m_cnt = '0;
    m_in_drop = '0;
    repeat (3) @(posedge cclk);
    @(negedge cclk);
    rst = 1'b0;
    for (int r = 0; r < num_rows; r++) begin
      if (exp_q.size() == 3) begin
        head = exp_q.pop_front();
        compare_outputs(head);
      end
      apply_row(r);
      @(negedge cclk);
    end
    // drain the last three rows
    repeat (3) begin
      head = exp_q.pop_front();
      compare_outputs(head);
      drive_idle();
      @(negedge cclk);
    end
    report_test(cur_test);
    $display("summary: %0d tests passed, %0d tests failed", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // watchdog sized from the table length
  initial begin
    #((num_rows + 20) * 40);
    $display("watchdog expired before the table finished");
    $display("Some tests failed");
    $finish;
  end

endmodule

//--- sources.f
+incdir+tests
logic/igr_pkg.sv
logic/igr_dpc.sv
logic/igr_pause_ctrl.sv
logic/igr_drop_ctrl.sv
logic/igr_top.sv
tests/igr_tb.sv

//--- run.sh
#!/bin/sh
# build and run with verilator, pass only when the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sources.f --top-module igr_tb || exit 1
out=$(./obj_dir/Vigr_tb)
echo "$out"
echo "$out" | grep -qx "All tests passed" && echo "run.sh: pass" || { echo "run.sh: fail"; exit 1; }
